// File: src.f
+incdir+verilog
verilog/adc_tpl_pkg.sv
verilog/adc_common_regs.sv
verilog/adc_channel_regs.sv
verilog/tpl_profile_regs.sv
verilog/up_bus_join.sv
verilog/adc_tpl_regmap.sv
verification/tb_adc_tpl_regmap.sv

// File: Makefile
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f src.f --top-module tb_adc_tpl_regmap -Mdir obj_dir
	./obj_dir/Vtb_adc_tpl_regmap | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_adc_tpl_regmap.sv
// Random-stimulus testbench that drives the ADC TPL register map and checks it against a model
`timescale 1ns/10ps
`default_nettype none
`include "adc_tpl_macros.svh"

module tb_adc_tpl_regmap;

  import adc_tpl_pkg::*;

  localparam int NCH   = `ADC_TPL_NUM_CHANNELS;
  localparam int NPROF = `ADC_TPL_NUM_PROFILES;
  localparam int SEL_W = $clog2(NPROF) + 1;

  // Addresses that no block decodes
  localparam up_addr_t UNMAPPED [10] = '{10'h001, 10'h003, 10'h012, 10'h018, 10'h102,
                                         10'h140, 10'h201, 10'h203, 10'h214, 10'h3ff};

  typedef struct packed {
    int          due;
    logic        is_read;
    logic [31:0] data;
  } resp_t;

  logic              link_clk;
  logic              adc_rst;
  logic              wreq;
  up_addr_t          waddr;
  logic [31:0]       wdata;
  logic              rreq;
  up_addr_t          raddr;
  logic              sync_status;
  logic              dovf;
  logic [NCH-1:0]    pn_err;
  logic [NCH-1:0]    pn_oos;
  logic [NPROF*8-1:0] jesd_m;
  logic [NPROF*8-1:0] jesd_l;
  logic [NPROF*8-1:0] jesd_s;
  logic [NPROF*8-1:0] jesd_f;
  logic [NPROF*8-1:0] jesd_n;
  logic [NPROF*8-1:0] jesd_np;
  wire               wack;
  wire               rack;
  wire [31:0]        rdata;
  wire               core_rst;
  wire               adc_sync;
  wire [NCH-1:0]     enable;
  wire [NCH-1:0]     dfmt_enable;
  wire [NCH-1:0]     dfmt_sign_extend;
  wire [NCH-1:0]     dfmt_type;
  wire [NCH*4-1:0]   pn_seq_sel;
  wire [SEL_W-1:0]   profile_sel;

  // Register model
  logic [31:0]       scratch_m;
  logic              rstn_m;
  logic              core_rst_m;
  logic              sync_m;
  logic              ovf_m;
  logic [7:0]        ctrl_m [NCH];
  logic [NCH-1:0]    perr_m;
  logic [NCH-1:0]    poos_m;
  logic [SEL_W-1:0]  sel_m;

  resp_t             resp_q [$];
  int                cycle;
  int                checks;
  int                errors;
  int                timeouts;
  int                flag_rate;
  logic              ovf_pulse;

  adc_tpl_regmap dut (
    .link_clk         (link_clk),
    .adc_rst          (adc_rst),
    .wreq             (wreq),
    .waddr            (waddr),
    .wdata            (wdata),
    .wack             (wack),
    .rreq             (rreq),
    .raddr            (raddr),
    .rdata            (rdata),
    .rack             (rack),
    .sync_status      (sync_status),
    .dovf             (dovf),
    .core_rst         (core_rst),
    .adc_sync         (adc_sync),
    .pn_err           (pn_err),
    .pn_oos           (pn_oos),
    .enable           (enable),
    .dfmt_enable      (dfmt_enable),
    .dfmt_sign_extend (dfmt_sign_extend),
    .dfmt_type        (dfmt_type),
    .pn_seq_sel       (pn_seq_sel),
    .jesd_m           (jesd_m),
    .jesd_l           (jesd_l),
    .jesd_s           (jesd_s),
    .jesd_f           (jesd_f),
    .jesd_n           (jesd_n),
    .jesd_np          (jesd_np),
    .profile_sel      (profile_sel)
  );

  always #2 link_clk = ~link_clk;

  function automatic up_addr_t chan_addr(input int ch, input up_addr_t off);
    chan_addr = up_addr_t'(`ADC_TPL_ADDR_CHAN_BASE + ch * `ADC_TPL_CHAN_STRIDE + off);
  endfunction

  function automatic up_addr_t prof_word(input int p, input int word);
    prof_word = up_addr_t'(`ADC_TPL_ADDR_PROFILE_BASE + 2 * p + word);
  endfunction

  // **************************************************
  // Model of the register map
  // **************************************************
  function automatic void model_read(input up_addr_t a, output logic hit,
                                     output logic [31:0] data);
    hit  = 1'b1;
    data = '0;
    case (a)
      `ADC_TPL_ADDR_VERSION:      data = `ADC_TPL_VERSION;
      `ADC_TPL_ADDR_SCRATCH:      data = scratch_m;
      `ADC_TPL_ADDR_RSTN:         data = {31'd0, rstn_m};
      `ADC_TPL_ADDR_SYNC:         data = '0;
      `ADC_TPL_ADDR_STATUS:       data = {27'd0, |pn_oos, |pn_err, ovf_m, sync_status, ~core_rst_m};
      `ADC_TPL_ADDR_PROFILE_SEL:  data = 32'(sel_m);
      `ADC_TPL_ADDR_NUM_PROFILES: data = 32'(NPROF);
      default:                    hit = 1'b0;
    endcase
    for (int i = 0; i < NCH; i++) begin
      if (a == chan_addr(i, `ADC_TPL_CHAN_CTRL)) begin
        hit  = 1'b1;
        data = {24'd0, ctrl_m[i]};
      end
      if (a == chan_addr(i, `ADC_TPL_CHAN_STAT)) begin
        hit  = 1'b1;
        data = {30'd0, poos_m[i], perr_m[i]};
      end
    end
    // Profile word 0 holds F S L M, word 1 holds NP N
    for (int p = 0; p < NPROF; p++) begin
      if (a == prof_word(p, 0)) begin
        hit  = 1'b1;
        data = {jesd_f[p*8+:8], jesd_s[p*8+:8], jesd_l[p*8+:8], jesd_m[p*8+:8]};
      end
      if (a == prof_word(p, 1)) begin
        hit  = 1'b1;
        data = {16'd0, jesd_np[p*8+:8], jesd_n[p*8+:8]};
      end
    end
  endfunction

  // Moves the model to the state of the next cycle
  task automatic advance_model();
    logic sync_n;
    logic core_n;
    logic clr_e;
    logic clr_o;
    sync_n = wreq && (waddr == `ADC_TPL_ADDR_SYNC) && wdata[0] && !sync_m;
    core_n = !rstn_m;
    if (wreq && (waddr == `ADC_TPL_ADDR_SCRATCH)) begin
      scratch_m = wdata;
    end
    if (wreq && (waddr == `ADC_TPL_ADDR_RSTN)) begin
      rstn_m = wdata[0];
    end
    ovf_m = (ovf_m && !(wreq && (waddr == `ADC_TPL_ADDR_STATUS) && wdata[2])) || dovf;
    for (int i = 0; i < NCH; i++) begin
      if (wreq && (waddr == chan_addr(i, `ADC_TPL_CHAN_CTRL))) begin
        ctrl_m[i] = wdata[7:0];
      end
      clr_e     = wreq && (waddr == chan_addr(i, `ADC_TPL_CHAN_STAT)) && wdata[0];
      clr_o     = wreq && (waddr == chan_addr(i, `ADC_TPL_CHAN_STAT)) && wdata[1];
      // A flag in the same cycle beats the clear
      perr_m[i] = (perr_m[i] && !clr_e) || pn_err[i];
      poos_m[i] = (poos_m[i] && !clr_o) || pn_oos[i];
    end
    if (wreq && (waddr == `ADC_TPL_ADDR_PROFILE_SEL)) begin
      sel_m = (wdata < NPROF) ? wdata[SEL_W-1:0] : '0;
    end
    sync_m     = sync_n;
    core_rst_m = core_n;
  endtask

  // **************************************************
  // Checks
  // **************************************************
  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic verify_outputs();
    logic        exp_w;
    logic        exp_r;
    logic [31:0] exp_d;
    resp_t       e;
    exp_w = 1'b0;
    exp_r = 1'b0;
    exp_d = '0;
    while (resp_q.size() > 0 && resp_q[0].due == cycle) begin
      e = resp_q.pop_front();
      if (e.is_read) begin
        exp_r = 1'b1;
        exp_d = e.data;
      end else begin
        exp_w = 1'b1;
      end
    end
    compare_bit("wack", wack, exp_w);
    compare_bit("rack", rack, exp_r);
    compare_word("rdata", rdata, exp_d);
    compare_bit("core_rst", core_rst, core_rst_m);
    compare_bit("adc_sync", adc_sync, sync_m);
    for (int i = 0; i < NCH; i++) begin
      compare_bit($sformatf("enable[%0d]", i), enable[i], ctrl_m[i][0]);
      compare_bit($sformatf("dfmt_enable[%0d]", i), dfmt_enable[i], ctrl_m[i][1]);
      compare_bit($sformatf("dfmt_sign_extend[%0d]", i), dfmt_sign_extend[i], ctrl_m[i][2]);
      compare_bit($sformatf("dfmt_type[%0d]", i), dfmt_type[i], ctrl_m[i][3]);
      compare_word($sformatf("pn_seq_sel[%0d]", i), 32'(pn_seq_sel[i*4+:4]),
                   32'(ctrl_m[i][7:4]));
    end
    compare_word("profile_sel", 32'(profile_sel), 32'(sel_m));
  endtask

  // **************************************************
  // Each cycle checks the outputs and then drives on the falling edge
  // **************************************************
  task automatic tick(input logic w, input up_addr_t wa, input logic [31:0] wd,
                      input logic r, input up_addr_t ra);
    logic        hit;
    logic [31:0] exp;
    resp_t       e;
    @(negedge link_clk);
    cycle++;
    verify_outputs();
    wreq  = w;
    waddr = wa;
    wdata = wd;
    rreq  = r;
    raddr = ra;
    if (flag_rate > 0) begin
      for (int i = 0; i < NCH; i++) begin
        pn_err[i] = ($urandom % flag_rate) == 0;
        pn_oos[i] = ($urandom % flag_rate) == 0;
      end
      dovf        = ovf_pulse || (($urandom % flag_rate) == 0);
      sync_status = ($urandom % 2) == 0;
    end else begin
      pn_err = '0;
      pn_oos = '0;
      dovf   = ovf_pulse;
    end
    ovf_pulse = 1'b0;
    // Responses are due two cycles after the strobe
    if (r) begin
      model_read(ra, hit, exp);
      if (hit) begin
        e.due     = cycle + 2;
        e.is_read = 1'b1;
        e.data    = exp;
        resp_q.push_back(e);
      end
    end
    if (w) begin
      model_read(wa, hit, exp);
      if (hit) begin
        e.due     = cycle + 2;
        e.is_read = 1'b0;
        e.data    = '0;
        resp_q.push_back(e);
      end
    end
    advance_model();
  endtask

  task automatic idle();
    tick(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic write_reg(input up_addr_t a, input logic [31:0] d);
    tick(1'b1, a, d, 1'b0, '0);
  endtask

  task automatic read_reg(input up_addr_t a);
    tick(1'b0, '0, '0, 1'b1, a);
  endtask

  function automatic up_addr_t pick_addr(input logic with_status);
    int sel;
    int ch;
    ch  = int'($urandom % NCH);
    sel = int'($urandom % (with_status ? 32'd4 : 32'd2));
    case (sel)
      0:       pick_addr = `ADC_TPL_ADDR_SCRATCH;
      1:       pick_addr = chan_addr(ch, `ADC_TPL_CHAN_CTRL);
      2:       pick_addr = chan_addr(ch, `ADC_TPL_CHAN_STAT);
      default: pick_addr = `ADC_TPL_ADDR_STATUS;
    endcase
  endfunction

  task automatic random_cycle(input logic with_status);
    logic     w;
    logic     r;
    up_addr_t wa;
    up_addr_t ra;
    w  = ($urandom % 2) == 0;
    r  = ($urandom % 2) == 0;
    wa = pick_addr(with_status);
    ra = pick_addr(with_status);
    tick(w, wa, $urandom, r, ra);
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while (resp_q.size() > 0 && n < 8) begin
      idle();
      n++;
    end
    if (resp_q.size() > 0) begin
      timeouts++;
      $display("Timeout: %0d bus responses were still outstanding", resp_q.size());
      resp_q.delete();
    end
  endtask

  task automatic wait_core_release();
    int n;
    n = 0;
    while (core_rst && n < 10) begin
      idle();
      n++;
    end
    if (core_rst) begin
      timeouts++;
      $display("Timeout: core_rst stayed high after the reset register was written");
    end
  endtask

  // Back-to-back sync writes still give one pulse
  task automatic count_sync_pulses(input int writes);
    int pulses;
    pulses = 0;
    for (int k = 0; k < writes; k++) begin
      write_reg(`ADC_TPL_ADDR_SYNC, 32'h1);
      if (k > 0 && adc_sync) begin
        pulses++;
      end
    end
    for (int n = 0; n < 6; n++) begin
      idle();
      if (adc_sync) begin
        pulses++;
      end
    end
    checks++;
    assert (pulses == 1) else begin
      errors++;
      $display("** Error at %0t: %0d adc_sync pulses after %0d sync writes, expected 1",
               $time, pulses, writes);
    end
  endtask

  initial begin
    link_clk    = 1'b0;
    adc_rst     = 1'b1;
    wreq        = 1'b0;
    waddr       = '0;
    wdata       = '0;
    rreq        = 1'b0;
    raddr       = '0;
    sync_status = 1'b0;
    dovf        = 1'b0;
    pn_err      = '0;
    pn_oos      = '0;
    scratch_m   = '0;
    rstn_m      = 1'b0;
    core_rst_m  = 1'b1;
    sync_m      = 1'b0;
    ovf_m       = 1'b0;
    perr_m      = '0;
    poos_m      = '0;
    sel_m       = '0;
    for (int i = 0; i < NCH; i++) begin
      ctrl_m[i] = '0;
    end
    cycle     = 0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    flag_rate = 0;
    ovf_pulse = 1'b0;
    void'($urandom(19));
    // Deframer parameters stay fixed for the whole run
    for (int p = 0; p < NPROF; p++) begin
      jesd_m[p*8+:8]  = 8'($urandom);
      jesd_l[p*8+:8]  = 8'($urandom);
      jesd_s[p*8+:8]  = 8'($urandom);
      jesd_f[p*8+:8]  = 8'($urandom);
      jesd_n[p*8+:8]  = 8'($urandom);
      jesd_np[p*8+:8] = 8'($urandom);
    end

    repeat (8) @(posedge link_clk);
    @(negedge link_clk);
    adc_rst = 1'b0;
    advance_model();

    // Reset values and constant words
    read_reg(`ADC_TPL_ADDR_VERSION);
    read_reg(`ADC_TPL_ADDR_SCRATCH);
    drain_responses();

    // Back-to-back traffic to scratch and channel control
    repeat (300) random_cycle(1'b0);
    drain_responses();

    // Sticky PN flags and live status summary
    flag_rate = 6;
    repeat (300) random_cycle(1'b1);
    flag_rate = 0;
    idle();
    for (int i = 0; i < NCH; i++) begin
      read_reg(chan_addr(i, `ADC_TPL_CHAN_STAT));
    end
    read_reg(`ADC_TPL_ADDR_STATUS);
    drain_responses();

    // **************************************************
    // Core reset, sync pulse and overflow
    // **************************************************
    write_reg(`ADC_TPL_ADDR_RSTN, 32'h1);
    wait_core_release();
    read_reg(`ADC_TPL_ADDR_RSTN);
    read_reg(`ADC_TPL_ADDR_STATUS);
    count_sync_pulses(1);
    count_sync_pulses(2);
    ovf_pulse = 1'b1;
    idle();
    read_reg(`ADC_TPL_ADDR_STATUS);
    write_reg(`ADC_TPL_ADDR_STATUS, 32'h4);
    read_reg(`ADC_TPL_ADDR_STATUS);
    drain_responses();

    // Profile words, count and selection
    for (int p = 0; p < NPROF; p++) begin
      read_reg(prof_word(p, 0));
      read_reg(prof_word(p, 1));
    end
    read_reg(`ADC_TPL_ADDR_NUM_PROFILES);
    for (int v = 0; v < 4; v++) begin
      write_reg(`ADC_TPL_ADDR_PROFILE_SEL, 32'(v));
      read_reg(`ADC_TPL_ADDR_PROFILE_SEL);
    end
    write_reg(`ADC_TPL_ADDR_PROFILE_SEL, 32'hffff_fff1);
    read_reg(`ADC_TPL_ADDR_PROFILE_SEL);
    drain_responses();

    // Unmapped words must stay silent
    for (int k = 0; k < 10; k++) begin
      write_reg(UNMAPPED[k], $urandom);
      read_reg(UNMAPPED[k]);
      repeat (4) idle();
    end
    drain_responses();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/adc_tpl_regmap.sv
// Top of the ADC TPL register map, connects the host bus to the register blocks and the join
`timescale 1ns/10ps
`default_nettype none
`include "adc_tpl_macros.svh"

module adc_tpl_regmap #(
  parameter int NUM_CHANNELS = `ADC_TPL_NUM_CHANNELS,
  parameter int NUM_PROFILES = `ADC_TPL_NUM_PROFILES
) (
  input  wire                           link_clk,
  input  wire                           adc_rst,
  input  wire                           wreq,
  input  wire adc_tpl_pkg::up_addr_t    waddr,
  input  wire [31:0]                    wdata,
  output logic                          wack,
  input  wire                           rreq,
  input  wire adc_tpl_pkg::up_addr_t    raddr,
  output logic [31:0]                   rdata,
  output logic                          rack,
  input  wire                           sync_status,
  input  wire                           dovf,
  output logic                          core_rst,
  output logic                          adc_sync,
  input  wire [NUM_CHANNELS-1:0]        pn_err,
  input  wire [NUM_CHANNELS-1:0]        pn_oos,
  output logic [NUM_CHANNELS-1:0]       enable,
  output logic [NUM_CHANNELS-1:0]       dfmt_enable,
  output logic [NUM_CHANNELS-1:0]       dfmt_sign_extend,
  output logic [NUM_CHANNELS-1:0]       dfmt_type,
  output logic [NUM_CHANNELS*4-1:0]     pn_seq_sel,
  input  wire [NUM_PROFILES*8-1:0]      jesd_m,
  input  wire [NUM_PROFILES*8-1:0]      jesd_l,
  input  wire [NUM_PROFILES*8-1:0]      jesd_s,
  input  wire [NUM_PROFILES*8-1:0]      jesd_f,
  input  wire [NUM_PROFILES*8-1:0]      jesd_n,
  input  wire [NUM_PROFILES*8-1:0]      jesd_np,
  output logic [$clog2(NUM_PROFILES):0] profile_sel
);

  // Peer 0 common, 1..NUM_CHANNELS channels, last one profiles
  localparam int NUM_PEERS = NUM_CHANNELS + 2;

  logic [NUM_PEERS-1:0]    wack_vec;
  logic [NUM_PEERS-1:0]    rack_vec;
  logic [NUM_PEERS*32-1:0] rdata_vec;

  adc_common_regs #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) i_common (
    .link_clk    (link_clk),
    .adc_rst     (adc_rst),
    .wreq        (wreq),
    .waddr       (waddr),
    .wdata       (wdata),
    .wack        (wack_vec[0]),
    .rreq        (rreq),
    .raddr       (raddr),
    .rdata       (rdata_vec[31:0]),
    .rack        (rack_vec[0]),
    .sync_status (sync_status),
    .dovf        (dovf),
    .pn_err      (pn_err),
    .pn_oos      (pn_oos),
    .core_rst    (core_rst),
    .adc_sync    (adc_sync)
  );

  // **************************************************
  // One register block per channel
  // **************************************************
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    adc_channel_regs #(
      .CHANNEL_INDEX (i)
    ) i_channel (
      .link_clk         (link_clk),
      .adc_rst          (adc_rst),
      .wreq             (wreq),
      .waddr            (waddr),
      .wdata            (wdata),
      .wack             (wack_vec[i+1]),
      .rreq             (rreq),
      .raddr            (raddr),
      .rdata            (rdata_vec[(i+1)*32+:32]),
      .rack             (rack_vec[i+1]),
      .enable           (enable[i]),
      .dfmt_enable      (dfmt_enable[i]),
      .dfmt_sign_extend (dfmt_sign_extend[i]),
      .dfmt_type        (dfmt_type[i]),
      .pn_seq_sel       (pn_seq_sel[i*4+:4]),
      .pn_err           (pn_err[i]),
      .pn_oos           (pn_oos[i])
    );
  end

  tpl_profile_regs #(
    .NUM_PROFILES (NUM_PROFILES)
  ) i_profile (
    .link_clk    (link_clk),
    .adc_rst     (adc_rst),
    .wreq        (wreq),
    .waddr       (waddr),
    .wdata       (wdata),
    .wack        (wack_vec[NUM_PEERS-1]),
    .rreq        (rreq),
    .raddr       (raddr),
    .rdata       (rdata_vec[(NUM_PEERS-1)*32+:32]),
    .rack        (rack_vec[NUM_PEERS-1]),
    .jesd_m      (jesd_m),
    .jesd_l      (jesd_l),
    .jesd_s      (jesd_s),
    .jesd_f      (jesd_f),
    .jesd_n      (jesd_n),
    .jesd_np     (jesd_np),
    .profile_sel (profile_sel)
  );

  up_bus_join #(
    .NUM_PEERS (NUM_PEERS)
  ) i_join (
    .link_clk  (link_clk),
    .adc_rst   (adc_rst),
    .wack_vec  (wack_vec),
    .rack_vec  (rack_vec),
    .rdata_vec (rdata_vec),
    .wack      (wack),
    .rack      (rack),
    .rdata     (rdata)
  );

endmodule

`default_nettype wire

// File: verilog/up_bus_join.sv
// Response join of the register bus, merges peer acknowledges and read data into one response
`timescale 1ns/10ps
`default_nettype none

module up_bus_join #(
  parameter int NUM_PEERS = 2
) (
  input  wire                   link_clk,
  input  wire                   adc_rst,
  input  wire [NUM_PEERS-1:0]   wack_vec,
  input  wire [NUM_PEERS-1:0]   rack_vec,
  input  wire [NUM_PEERS*32-1:0] rdata_vec,
  output logic                  wack,
  output logic                  rack,
  output logic [31:0]           rdata
);

  logic [31:0] rdata_or;

  // Idle peers return zero, so an OR picks the active one
  always_comb begin
    rdata_or = '0;
    for (int i = 0; i < NUM_PEERS; i++) begin
      rdata_or = rdata_or | rdata_vec[i*32+:32];
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      wack  <= 1'b0;
      rack  <= 1'b0;
      rdata <= '0;
    end else begin
      wack  <= |wack_vec;
      rack  <= |rack_vec;
      rdata <= rdata_or;
    end
  end

  // Address windows must not overlap
  a_one_wack : assert property (
    @(posedge link_clk) disable iff (adc_rst) $onehot0(wack_vec)
  ) else $error("more than one peer acknowledged a write");

  a_one_rack : assert property (
    @(posedge link_clk) disable iff (adc_rst) $onehot0(rack_vec)
  ) else $error("more than one peer acknowledged a read");

endmodule

`default_nettype wire

// File: verilog/tpl_profile_regs.sv
// JESD profile register block of the ADC TPL register map, reports link parameters per profile
`timescale 1ns/10ps
`default_nettype none
`include "adc_tpl_macros.svh"

module tpl_profile_regs #(
  parameter int NUM_PROFILES = `ADC_TPL_NUM_PROFILES
) (
  input  wire                          link_clk,
  input  wire                          adc_rst,
  input  wire                          wreq,
  input  wire adc_tpl_pkg::up_addr_t   waddr,
  input  wire [31:0]                   wdata,
  output logic                         wack,
  input  wire                          rreq,
  input  wire adc_tpl_pkg::up_addr_t   raddr,
  output logic [31:0]                  rdata,
  output logic                         rack,
  input  wire [NUM_PROFILES*8-1:0]     jesd_m,
  input  wire [NUM_PROFILES*8-1:0]     jesd_l,
  input  wire [NUM_PROFILES*8-1:0]     jesd_s,
  input  wire [NUM_PROFILES*8-1:0]     jesd_f,
  input  wire [NUM_PROFILES*8-1:0]     jesd_n,
  input  wire [NUM_PROFILES*8-1:0]     jesd_np,
  output logic [$clog2(NUM_PROFILES):0] profile_sel
);

  import adc_tpl_pkg::*;

  localparam int SEL_W = $clog2(NUM_PROFILES) + 1;

  logic        sel_wr;
  logic        rd_hit;
  logic [31:0] rd_word;

  function automatic up_addr_t prof_addr(int p, int word);
    prof_addr = up_addr_t'(`ADC_TPL_ADDR_PROFILE_BASE + 2 * p + word);
  endfunction

  // Profile words past the last profile stay unmapped
  function automatic logic is_mapped(up_addr_t addr);
    is_mapped = (addr == `ADC_TPL_ADDR_PROFILE_SEL) || (addr == `ADC_TPL_ADDR_NUM_PROFILES);
    for (int p = 0; p < NUM_PROFILES; p++) begin
      if ((addr == prof_addr(p, 0)) || (addr == prof_addr(p, 1))) begin
        is_mapped = 1'b1;
      end
    end
  endfunction

  assign sel_wr = wreq && (waddr == `ADC_TPL_ADDR_PROFILE_SEL);
  assign rd_hit = is_mapped(raddr);

  always_comb begin
    rd_word = '0;
    if (raddr == `ADC_TPL_ADDR_PROFILE_SEL) begin
      rd_word = 32'(profile_sel);
    end else if (raddr == `ADC_TPL_ADDR_NUM_PROFILES) begin
      rd_word = 32'(NUM_PROFILES);
    end
    for (int p = 0; p < NUM_PROFILES; p++) begin
      // F S L M from the top byte down
      if (raddr == prof_addr(p, 0)) begin
        rd_word = {jesd_f[p*8+:8], jesd_s[p*8+:8], jesd_l[p*8+:8], jesd_m[p*8+:8]};
      end
      if (raddr == prof_addr(p, 1)) begin
        rd_word = {16'd0, jesd_np[p*8+:8], jesd_n[p*8+:8]};
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      profile_sel <= '0;
      wack        <= 1'b0;
      rack        <= 1'b0;
      rdata       <= '0;
    end else begin
      // Out of range selections fall back to profile 0
      if (sel_wr) begin
        profile_sel <= (wdata < NUM_PROFILES) ? wdata[SEL_W-1:0] : '0;
      end
      wack  <= wreq & is_mapped(waddr);
      rack  <= rreq & rd_hit;
      rdata <= (rreq && rd_hit) ? rd_word : 32'd0;
    end
  end

  a_sel_range : assert property (
    @(posedge link_clk) disable iff (adc_rst) sel_wr |=> (profile_sel < NUM_PROFILES)
  ) else $error("profile_sel out of range after write");

endmodule

`default_nettype wire

// File: verilog/adc_channel_regs.sv
// Per-channel register block of the ADC TPL register map, one instance per converter channel
`timescale 1ns/10ps
`default_nettype none
`include "adc_tpl_macros.svh"

module adc_channel_regs #(
  parameter int CHANNEL_INDEX = 0
) (
  input  wire                        link_clk,
  input  wire                        adc_rst,
  input  wire                        wreq,
  input  wire adc_tpl_pkg::up_addr_t waddr,
  input  wire [31:0]                 wdata,
  output logic                       wack,
  input  wire                        rreq,
  input  wire adc_tpl_pkg::up_addr_t raddr,
  output logic [31:0]                rdata,
  output logic                       rack,
  output logic                       enable,
  output logic                       dfmt_enable,
  output logic                       dfmt_sign_extend,
  output logic                       dfmt_type,
  output logic [3:0]                 pn_seq_sel,
  input  wire                        pn_err,
  input  wire                        pn_oos
);

  import adc_tpl_pkg::*;

  // Window of this channel
  localparam up_addr_t CTRL_ADDR = up_addr_t'(`ADC_TPL_ADDR_CHAN_BASE +
    CHANNEL_INDEX * `ADC_TPL_CHAN_STRIDE + `ADC_TPL_CHAN_CTRL);
  localparam up_addr_t STAT_ADDR = up_addr_t'(`ADC_TPL_ADDR_CHAN_BASE +
    CHANNEL_INDEX * `ADC_TPL_CHAN_STRIDE + `ADC_TPL_CHAN_STAT);

  chan_ctrl_t ctrl_q;
  logic       pn_err_q;
  logic       pn_oos_q;
  reg_word_t  wr_word;
  reg_word_t  rd_word;
  logic       ctrl_wr;
  logic       stat_wr;
  logic       rd_hit;

  assign wr_word = wdata;
  assign ctrl_wr = wreq && (waddr == CTRL_ADDR);
  assign stat_wr = wreq && (waddr == STAT_ADDR);
  assign rd_hit  = (raddr == CTRL_ADDR) || (raddr == STAT_ADDR);

  // Channel controls come straight from the control word
  assign enable           = ctrl_q.enable;
  assign dfmt_enable      = ctrl_q.dfmt_enable;
  assign dfmt_sign_extend = ctrl_q.dfmt_sign_extend;
  assign dfmt_type        = ctrl_q.dfmt_type;
  assign pn_seq_sel       = ctrl_q.pn_seq_sel;

  // **************************************************
  // Read data, built through the same union
  // **************************************************
  always_comb begin
    rd_word = '0;
    if (raddr == CTRL_ADDR) begin
      rd_word.ctrl = ctrl_q;
    end else if (raddr == STAT_ADDR) begin
      rd_word.stat.pn_err = pn_err_q;
      rd_word.stat.pn_oos = pn_oos_q;
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      ctrl_q   <= '0;
      pn_err_q <= 1'b0;
      pn_oos_q <= 1'b0;
      wack     <= 1'b0;
      rack     <= 1'b0;
      rdata    <= '0;
    end else begin
      // Reserved bits stay zero
      if (ctrl_wr) begin
        ctrl_q.enable           <= wr_word.ctrl.enable;
        ctrl_q.dfmt_enable      <= wr_word.ctrl.dfmt_enable;
        ctrl_q.dfmt_sign_extend <= wr_word.ctrl.dfmt_sign_extend;
        ctrl_q.dfmt_type        <= wr_word.ctrl.dfmt_type;
        ctrl_q.pn_seq_sel       <= wr_word.ctrl.pn_seq_sel;
      end
      // Sticky flags, a new flag beats the clear
      pn_err_q <= (pn_err_q & ~(stat_wr & wr_word.stat.pn_err)) | pn_err;
      pn_oos_q <= (pn_oos_q & ~(stat_wr & wr_word.stat.pn_oos)) | pn_oos;
      wack  <= ctrl_wr | stat_wr;
      rack  <= rreq & rd_hit;
      rdata <= (rreq && rd_hit) ? rd_word : 32'd0;
    end
  end

  a_pn_sel_write : assert property (
    @(posedge link_clk) disable iff (adc_rst) !$stable(pn_seq_sel) |-> $past(ctrl_wr)
  ) else $error("pn_seq_sel changed without a control write");

endmodule

`default_nettype wire

// File: verilog/adc_common_regs.sv
// Common register block of the ADC TPL register map, answers the common address window
`timescale 1ns/10ps
`default_nettype none
`include "adc_tpl_macros.svh"

module adc_common_regs #(
  parameter int NUM_CHANNELS = `ADC_TPL_NUM_CHANNELS
) (
  input  wire                    link_clk,
  input  wire                    adc_rst,
  input  wire                    wreq,
  input  wire adc_tpl_pkg::up_addr_t waddr,
  input  wire [31:0]             wdata,
  output logic                   wack,
  input  wire                    rreq,
  input  wire adc_tpl_pkg::up_addr_t raddr,
  output logic [31:0]            rdata,
  output logic                   rack,
  input  wire                    sync_status,
  input  wire                    dovf,
  input  wire [NUM_CHANNELS-1:0] pn_err,
  input  wire [NUM_CHANNELS-1:0] pn_oos,
  output logic                   core_rst,
  output logic                   adc_sync
);

  import adc_tpl_pkg::*;

  logic [31:0] scratch_q;
  logic        rstn_q;
  logic        ovf_q;
  logic        scratch_wr;
  logic        rstn_wr;
  logic        sync_wr;
  logic        status_wr;
  logic        rd_hit;
  logic [31:0] rd_word;

  function automatic logic is_mapped(up_addr_t addr);
    case (addr)
      `ADC_TPL_ADDR_VERSION,
      `ADC_TPL_ADDR_SCRATCH,
      `ADC_TPL_ADDR_RSTN,
      `ADC_TPL_ADDR_SYNC,
      `ADC_TPL_ADDR_STATUS: is_mapped = 1'b1;
      default: is_mapped = 1'b0;
    endcase
  endfunction

  assign scratch_wr = wreq && (waddr == `ADC_TPL_ADDR_SCRATCH);
  assign rstn_wr    = wreq && (waddr == `ADC_TPL_ADDR_RSTN);
  assign sync_wr    = wreq && (waddr == `ADC_TPL_ADDR_SYNC);
  assign status_wr  = wreq && (waddr == `ADC_TPL_ADDR_STATUS);

  // **************************************************
  // Read mux
  // **************************************************
  always_comb begin
    rd_hit  = is_mapped(raddr);
    rd_word = '0;
    case (raddr)
      `ADC_TPL_ADDR_VERSION: rd_word = `ADC_TPL_VERSION;
      `ADC_TPL_ADDR_SCRATCH: rd_word = scratch_q;
      `ADC_TPL_ADDR_RSTN:    rd_word = {31'd0, rstn_q};
      // Summary of core and channel state
      `ADC_TPL_ADDR_STATUS:  rd_word = {27'd0, |pn_oos, |pn_err, ovf_q, sync_status, ~core_rst};
      default:               rd_word = '0;
    endcase
  end

  // **************************************************
  // Registers and bus response
  // **************************************************
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      scratch_q <= '0;
      rstn_q    <= 1'b0;
      core_rst  <= 1'b1;
      adc_sync  <= 1'b0;
      ovf_q     <= 1'b0;
      wack      <= 1'b0;
      rack      <= 1'b0;
      rdata     <= '0;
    end else begin
      if (scratch_wr) begin
        scratch_q <= wdata;
      end
      if (rstn_wr) begin
        rstn_q <= wdata[0];
      end
      // Core reset trails the register by one cycle
      core_rst <= ~rstn_q;
      // Single pulse even for back-to-back sync writes
      adc_sync <= sync_wr & wdata[0] & ~adc_sync;
      // Set wins over write-1-to-clear
      ovf_q <= (ovf_q & ~(status_wr & wdata[2])) | dovf;
      wack  <= wreq & is_mapped(waddr);
      rack  <= rreq & rd_hit;
      rdata <= (rreq && rd_hit) ? rd_word : 32'd0;
    end
  end

  a_sync_single : assert property (
    @(posedge link_clk) disable iff (adc_rst) adc_sync |=> !adc_sync
  ) else $error("adc_sync held high for two cycles");

endmodule

`default_nettype wire

// File: verilog/adc_tpl_pkg.sv
// Shared register types of the ADC TPL register map, imported by the register blocks
`default_nettype none

package adc_tpl_pkg;

  // Word address on the register bus
  typedef logic [9:0] up_addr_t;

  // Channel control word, enable in bit 0
  typedef struct packed {
    logic [23:0] reserved;
    logic [3:0]  pn_seq_sel;
    logic        dfmt_type;
    logic        dfmt_sign_extend;
    logic        dfmt_enable;
    logic        enable;
  } chan_ctrl_t;

  // Channel status word, pn_err in bit 0
  typedef struct packed {
    logic [29:0] reserved;
    logic        pn_oos;
    logic        pn_err;
  } chan_stat_t;

  // One bus word, seen as control or as status
  typedef union packed {
    chan_ctrl_t ctrl;
    chan_stat_t stat;
  } reg_word_t;

endpackage

`default_nettype wire

// File: verilog/adc_tpl_macros.svh
// Default sizes, version word and register word addresses of the ADC TPL register map
`ifndef ADC_TPL_MACROS_SVH
`define ADC_TPL_MACROS_SVH

// Default core configuration
`define ADC_TPL_NUM_CHANNELS 4
`define ADC_TPL_NUM_PROFILES 2
`define ADC_TPL_VERSION 32'h000b0162

// **************************************************
// Common window
// **************************************************
`define ADC_TPL_ADDR_VERSION 10'h000
`define ADC_TPL_ADDR_SCRATCH 10'h002
`define ADC_TPL_ADDR_RSTN 10'h010
`define ADC_TPL_ADDR_SYNC 10'h011
`define ADC_TPL_ADDR_STATUS 10'h017

// **************************************************
// Channel window, one stride per channel
// **************************************************
`define ADC_TPL_ADDR_CHAN_BASE 10'h100
`define ADC_TPL_CHAN_STRIDE 10'h010
`define ADC_TPL_CHAN_CTRL 10'h000
`define ADC_TPL_CHAN_STAT 10'h001

// **************************************************
// Profile window, two words per profile
// **************************************************
`define ADC_TPL_ADDR_PROFILE_SEL 10'h200
`define ADC_TPL_ADDR_NUM_PROFILES 10'h202
`define ADC_TPL_ADDR_PROFILE_BASE 10'h210

`endif
